// ==== test/mxint_mac_tests.txt ====
// first word: number of groups; then per group two pair lines and one result line
// pair: a_man0..3 a_exp b_man0..3 b_exp    result: out_man0..3 out_exp (hex)
0c
// equal exponents
1 2 3 4 02  1 1 1 1 02
f 2 d 5 02  2 2 2 2 02
ff 06 fd 0e 04
7 8 3 e fd  7 7 b a fd
9 6 0 1 fd  3 c 5 7 fd
1c b0 f1 13 fa
// differing exponents, held side larger then incoming side larger
5 d 7 2 03  4 3 6 9 01
3 b f 7 00  3 3 5 1 02
16 f3 28 f3 04
6 8 1 f 00  5 2 d f 00
2 2 e 4 01  2 f 3 d 02
07 fc f9 f4 03
7 8 3 f f6  7 7 1 1 f6
1 1 1 1 05  1 2 3 e 05
01 01 03 fd 0a
// exponent sums clamped high then low
2 3 c 1 64  3 3 3 b 64
1 e 2 7 7f  4 4 4 4 01
0a 01 fc 17 7f
8 7 5 0 9c  f 1 e 6 9c
3 3 3 3 80  1 f 2 e ff
0b 04 fc fa 80
// sums past 8 bits, shifted by one
8 8 7 9 02  8 8 7 3 01
8 4 7 b 03  8 8 9 5 00
40 10 00 e9 04
8 3 9 5 00  8 d 1 d 00
8 7 9 1 00  8 e 3 2 00
40 f4 f2 f9 01
8 1 2 3 7f  8 1 1 1 10
8 f e d 40  8 1 1 1 40
40 00 00 00 7f
// negative values truncated toward minus infinity
f f f f 01  1 1 1 1 00
0 0 0 0 02  3 5 7 2 03
ff ff ff ff 05
0 0 0 0 00  0 0 0 0 00
7 7 7 7 ff  8 8 8 8 ff
f2 f2 f2 f2 00

// ==== filelist.f ====
+incdir+verilog
verilog/mxint_pkg.sv
verilog/mxint_block_mul.sv
verilog/mxint_accumulator.sv
verilog/mxint_cast.sv
verilog/mxint_mac_top.sv
test/mxint_mac_checker.sv
test/mxint_mac_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module mxint_mac_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vmxint_mac_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== test/mxint_mac_tb.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_mac_tb;

  // one pair: a_man, a_exp, b_man, b_exp
  localparam int PAIR_WORDS  = 2 * (`MX_BLOCK_SIZE + 1);
  localparam int OUT_WORDS   = `MX_BLOCK_SIZE + 1;
  localparam int GROUP_WORDS = `MX_IN_DEPTH * PAIR_WORDS + OUT_WORDS;
  localparam int MEM_WORDS   = 1024;
  // full rate first, then random back-pressure
  localparam int PASSES      = 2;

  logic                 clk;
  logic                 rst;
  mxint_pkg::man_t      a_man [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::exp_t      a_exp;
  mxint_pkg::man_t      b_man [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::exp_t      b_exp;
  logic                 in_valid;
  logic                 in_ready;
  mxint_pkg::out_man_t  out_man [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::exp_t      out_exp;
  logic                 out_valid;
  logic                 out_ready;

  logic [7:0]           tests_mem [0:MEM_WORDS-1];
  int                   n_groups;
  int                   groups_done;
  int                   errors;
  int                   cycles;
  int                   cycle_limit;
  bit                   group_ok;
  logic                 random_ready;
  logic [31:0]          rng;
  string                pass_name;

  mxint_mac_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .a_man     (a_man),
    .a_exp     (a_exp),
    .b_man     (b_man),
    .b_exp     (b_exp),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_man   (out_man),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word 0 of the file is the group count
  function automatic int group_base(input int g);
    return 1 + g * GROUP_WORDS;
  endfunction

  task automatic check_man(input mxint_pkg::out_man_t got, input mxint_pkg::out_man_t want,
                           input string what);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s got %0d, expected %0d", $time, what, got, want);
      errors++;
      group_ok = 1'b0;
    end
  endtask

  task automatic check_exp(input mxint_pkg::exp_t got, input mxint_pkg::exp_t want,
                           input string what);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s got %0d, expected %0d", $time, what, got, want);
      errors++;
      group_ok = 1'b0;
    end
  endtask

  task automatic load_pair(input int g, input int p);
    int pb;
    pb = group_base(g) + p * PAIR_WORDS;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      a_man[i] = mxint_pkg::man_t'(tests_mem[pb + i]);
      b_man[i] = mxint_pkg::man_t'(tests_mem[pb + `MX_BLOCK_SIZE + 1 + i]);
    end
    a_exp = mxint_pkg::exp_t'(tests_mem[pb + `MX_BLOCK_SIZE]);
    b_exp = mxint_pkg::exp_t'(tests_mem[pb + 2 * `MX_BLOCK_SIZE + 1]);
  endtask

  // ready is stable between the drive point and the next edge
  task automatic wait_accept();
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic send_all_groups();
    for (int g = 0; g < n_groups; g++) begin
      for (int p = 0; p < `MX_IN_DEPTH; p++) begin
        load_pair(g, p);
        in_valid = 1'b1;
        wait_accept();
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic check_output();
    int g;
    int eb;
    g = groups_done % n_groups;
    eb = group_base(g) + `MX_IN_DEPTH * PAIR_WORDS;
    group_ok = 1'b1;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      check_man(out_man[i], mxint_pkg::out_man_t'(tests_mem[eb + i]),
                $sformatf("group %0d out_man[%0d]", g, i));
    end
    check_exp(out_exp, mxint_pkg::exp_t'(tests_mem[eb + `MX_BLOCK_SIZE]),
              $sformatf("group %0d out_exp", g));
    $display("group %2d, %s: %s", g, pass_name, group_ok ? "ok" : "mismatch");
    groups_done++;
  endtask

  // back-pressure source
  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      rng = xorshift32(rng);
      out_ready = rng[3];
    end else begin
      out_ready = 1'b1;
    end
  end

  // output blocks are taken on the edge after this sample
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (groups_done >= PASSES * n_groups) begin
        $display("unexpected output block after the last group at %0d ns", $time);
        errors++;
      end else begin
        check_output();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: output blocks stopped arriving, %0d of %0d received in %0d cycles",
               groups_done, PASSES * n_groups, cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst          = 1'b1;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    a_exp        = '0;
    b_exp        = '0;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      a_man[i] = '0;
      b_man[i] = '0;
    end
    random_ready = 1'b0;
    rng          = 32'hebbab692;
    groups_done  = 0;
    errors       = 0;
    cycles       = 0;
    pass_name    = "full rate";

    $readmemh("test/mxint_mac_tests.txt", tests_mem);
    n_groups    = int'(tests_mem[0]);
    cycle_limit = PASSES * n_groups * `MX_IN_DEPTH * 20 + 100;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // input held valid back to back, output always ready
    send_all_groups();
    wait (groups_done == n_groups);
    @(posedge clk);
    #1;

    pass_name    = "random ready";
    random_ready = 1'b1;
    send_all_groups();
    wait (groups_done == PASSES * n_groups);

    // catch any surplus block
    repeat (10) @(posedge clk);

    $display("groups checked: %0d, value errors: %0d, assertion failures: %0d",
             groups_done, errors, i_dut.i_checker.fail_count);
    if (errors == 0 && i_dut.i_checker.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== test/mxint_mac_checker.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_mac_checker (
  input logic                 clk,
  input logic                 rst,
  input mxint_pkg::man_t      a_man [`MX_BLOCK_SIZE-1:0],
  input mxint_pkg::exp_t      a_exp,
  input mxint_pkg::man_t      b_man [`MX_BLOCK_SIZE-1:0],
  input mxint_pkg::exp_t      b_exp,
  input logic                 in_valid,
  input logic                 in_ready,
  input mxint_pkg::out_man_t  out_man [`MX_BLOCK_SIZE-1:0],
  input mxint_pkg::exp_t      out_exp,
  input logic                 out_valid,
  input logic                 out_ready
);

  localparam int IN_W  = 2 * `MX_BLOCK_SIZE * `MX_MAN_W;
  localparam int OUT_W = `MX_BLOCK_SIZE * `MX_OUT_MAN_W;

  logic [IN_W-1:0]   in_man_flat;
  logic [OUT_W-1:0]  out_man_flat;
  int unsigned       fail_count = 0;

  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_flat
    assign in_man_flat[i*2*`MX_MAN_W +: 2*`MX_MAN_W] = {a_man[i], b_man[i]};
    assign out_man_flat[i*`MX_OUT_MAN_W +: `MX_OUT_MAN_W] = out_man[i];
  end

  // stalled input pair stays put
  in_hold: assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable({in_man_flat, a_exp, b_exp}))
    else begin
      $error("input pair changed while stalled");
      fail_count++;
    end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable({out_man_flat, out_exp}))
    else begin
      $error("output block changed while stalled");
      fail_count++;
    end

  after_reset: assert property (@(posedge clk) $past(rst) |-> !out_valid && in_ready)
    else begin
      $error("handshake not idle after reset");
      fail_count++;
    end

endmodule

bind mxint_mac_top mxint_mac_checker i_checker (
  .clk       (clk),
  .rst       (rst),
  .a_man     (a_man),
  .a_exp     (a_exp),
  .b_man     (b_man),
  .b_exp     (b_exp),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_man   (out_man),
  .out_exp   (out_exp),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// ==== verilog/mxint_mac_top.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_mac_top (
  input  logic                 clk,
  input  logic                 rst,

  input  mxint_pkg::man_t      a_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t      a_exp,
  input  mxint_pkg::man_t      b_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t      b_exp,
  input  logic                 in_valid,
  output logic                 in_ready,

  output mxint_pkg::out_man_t  out_man [`MX_BLOCK_SIZE-1:0],
  output mxint_pkg::exp_t      out_exp,
  output logic                 out_valid,
  input  logic                 out_ready
);

  // multiplier to accumulator
  mxint_pkg::prod_t  p_man [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::exp_t   p_exp;
  logic              p_valid;
  logic              p_ready;

  // accumulator to cast
  mxint_pkg::acc_t   acc_man [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::exp_t   acc_exp;
  logic              acc_valid;
  logic              acc_ready;

  mxint_block_mul i_mul (
    .clk       (clk),
    .rst       (rst),
    .a_man     (a_man),
    .a_exp     (a_exp),
    .b_man     (b_man),
    .b_exp     (b_exp),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .p_man     (p_man),
    .p_exp     (p_exp),
    .out_valid (p_valid),
    .out_ready (p_ready)
  );

  mxint_accumulator i_acc (
    .clk       (clk),
    .rst       (rst),
    .in_man    (p_man),
    .in_exp    (p_exp),
    .in_valid  (p_valid),
    .in_ready  (p_ready),
    .acc_man   (acc_man),
    .acc_exp   (acc_exp),
    .out_valid (acc_valid),
    .out_ready (acc_ready)
  );

  mxint_cast i_cast (
    .clk       (clk),
    .rst       (rst),
    .in_man    (acc_man),
    .in_exp    (acc_exp),
    .in_valid  (acc_valid),
    .in_ready  (acc_ready),
    .out_man   (out_man),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== verilog/mxint_cast.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_cast (
  input  logic                 clk,
  input  logic                 rst,

  input  mxint_pkg::acc_t      in_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t      in_exp,
  input  logic                 in_valid,
  output logic                 in_ready,

  output mxint_pkg::out_man_t  out_man [`MX_BLOCK_SIZE-1:0],
  output mxint_pkg::exp_t      out_exp,
  output logic                 out_valid,
  input  logic                 out_ready
);

  localparam int ACC_W   = $bits(mxint_pkg::acc_t);
  localparam int OUT_W   = `MX_OUT_MAN_W;
  // largest shift that can ever be needed
  localparam int EXTRA   = (ACC_W > OUT_W) ? ACC_W - OUT_W : 0;
  localparam int SHIFT_W = $clog2(EXTRA + 2);

  logic [SHIFT_W-1:0]          shift;
  logic signed [`MX_EXP_W:0]   exp_wide;
  mxint_pkg::exp_t             exp_next;
  mxint_pkg::out_man_t         man_next [`MX_BLOCK_SIZE-1:0];
  logic                        accept;

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // smallest shift at which the whole block fits
  // walks down so the last fitting candidate wins
  always_comb begin : find_shift
    mxint_pkg::acc_t v;
    logic            all_fit;
    shift = SHIFT_W'(EXTRA);
    for (int s = EXTRA; s >= 0; s--) begin
      all_fit = 1'b1;
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        v = in_man[i] >>> s;
        if (mxint_pkg::acc_t'(mxint_pkg::out_man_t'(v)) != v) begin
          all_fit = 1'b0;
        end
      end
      if (all_fit) begin
        shift = SHIFT_W'(s);
      end
    end
  end

  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_shift
    assign man_next[i] = mxint_pkg::out_man_t'(in_man[i] >>> shift);
  end

  // exponent grows by the shift, saturating at the top
  always_comb begin
    exp_wide = in_exp;
    exp_wide = exp_wide + $signed({1'b0, shift});
    if (exp_wide > mxint_pkg::exp_max) begin
      exp_next = mxint_pkg::exp_max;
    end else begin
      exp_next = mxint_pkg::exp_t'(exp_wide);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_man <= man_next;
      out_exp <= exp_next;
    end
  end

endmodule

// ==== verilog/mxint_accumulator.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_accumulator (
  input  logic               clk,
  input  logic               rst,

  input  mxint_pkg::prod_t   in_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t    in_exp,
  input  logic               in_valid,
  output logic               in_ready,

  output mxint_pkg::acc_t    acc_man [`MX_BLOCK_SIZE-1:0],
  output mxint_pkg::exp_t    acc_exp,
  output logic               out_valid,
  input  logic               out_ready
);

  // one bit wider so the full depth itself fits
  localparam int CNT_W = $clog2(`MX_IN_DEPTH) + 1;

  logic [CNT_W-1:0]            count;
  logic                        accept;
  logic                        load;

  logic signed [`MX_EXP_W:0]   exp_diff;
  logic [`MX_EXP_W:0]          shift_amt;
  logic                        acc_bigger;
  mxint_pkg::exp_t             big_exp;
  logic [`MX_EXP_W:0]          in_shift;
  logic [`MX_EXP_W:0]          acc_shift;

  mxint_pkg::acc_t             ext_in [`MX_BLOCK_SIZE-1:0];
  mxint_pkg::acc_t             sum    [`MX_BLOCK_SIZE-1:0];

  assign out_valid = (count == CNT_W'(`MX_IN_DEPTH));

  // when full, a new block only enters as the result leaves
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // nothing held, or the held sum is leaving
  assign load = (count == '0) || out_valid;

  // block counter
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (out_valid) begin
      if (out_ready) begin
        count <= in_valid ? CNT_W'(1) : '0;
      end
    end else if (in_valid) begin
      count <= count + 1'b1;
    end
  end

  // exponent alignment
  // a negative difference means the incoming block has the larger exponent
  assign exp_diff   = acc_exp - in_exp;
  assign acc_bigger = !exp_diff[`MX_EXP_W];
  assign shift_amt  = acc_bigger ? exp_diff : -exp_diff;
  assign big_exp    = acc_bigger ? acc_exp : in_exp;

  // only the smaller side is shifted
  assign in_shift  = acc_bigger ? shift_amt : '0;
  assign acc_shift = acc_bigger ? '0 : shift_amt;

  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_align
    // sign extend the product to accumulator width
    assign ext_in[i] = mxint_pkg::acc_t'(in_man[i]);

    // arithmetic shift truncates toward minus infinity
    assign sum[i] = (ext_in[i] >>> in_shift) + (acc_man[i] >>> acc_shift);
  end

  // mantissa register, loaded unshifted at the start of a group
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
        acc_man[i] <= load ? ext_in[i] : sum[i];
      end
    end
  end

  // exponent register
  // the first block of a group replaces it without a comparison
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_exp <= mxint_pkg::exp_min;
    end else if (accept) begin
      acc_exp <= load ? in_exp : big_exp;
    end
  end

endmodule

// ==== verilog/mxint_block_mul.sv ====
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_block_mul (
  input  logic               clk,
  input  logic               rst,

  input  mxint_pkg::man_t    a_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t    a_exp,
  input  mxint_pkg::man_t    b_man [`MX_BLOCK_SIZE-1:0],
  input  mxint_pkg::exp_t    b_exp,
  input  logic               in_valid,
  output logic               in_ready,

  output mxint_pkg::prod_t   p_man [`MX_BLOCK_SIZE-1:0],
  output mxint_pkg::exp_t    p_exp,
  output logic               out_valid,
  input  logic               out_ready
);

  mxint_pkg::prod_t            man_next [`MX_BLOCK_SIZE-1:0];
  logic signed [`MX_EXP_W:0]   exp_sum;
  mxint_pkg::exp_t             exp_next;
  logic                        accept;

  // register empty, or being drained this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // elementwise signed product, full width so nothing is lost
  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_mul
    assign man_next[i] = a_man[i] * b_man[i];
  end

  // one extra bit holds the raw exponent sum
  assign exp_sum = a_exp + b_exp;

  always_comb begin
    if (exp_sum > mxint_pkg::exp_max) begin
      exp_next = mxint_pkg::exp_max;
    end else if (exp_sum < mxint_pkg::exp_min) begin
      exp_next = mxint_pkg::exp_min;
    end else begin
      exp_next = mxint_pkg::exp_t'(exp_sum);
    end
  end

  // valid follows the input whenever the register may change
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on a transfer, held otherwise
  always_ff @(posedge clk) begin
    if (accept) begin
      p_man <= man_next;
      p_exp <= exp_next;
    end
  end

endmodule

// ==== verilog/mxint_pkg.sv ====
`include "mxint_defs.svh"

package mxint_pkg;

  // input mantissa
  typedef logic signed [`MX_MAN_W-1:0] man_t;

  // shared exponent
  typedef logic signed [`MX_EXP_W-1:0] exp_t;

  // full-precision product of two mantissas
  typedef logic signed [2*`MX_MAN_W-1:0] prod_t;

  // one bit of growth per doubling of the depth
  typedef logic signed [2*`MX_MAN_W+$clog2(`MX_IN_DEPTH)-1:0] acc_t;

  // output mantissa after renormalisation
  typedef logic signed [`MX_OUT_MAN_W-1:0] out_man_t;

  // exponent range limits
  localparam exp_t exp_min = exp_t'(-(2 ** (`MX_EXP_W - 1)));
  localparam exp_t exp_max = exp_t'(2 ** (`MX_EXP_W - 1) - 1);

endpackage

// ==== verilog/mxint_defs.svh ====
`ifndef MXINT_DEFS_SVH
`define MXINT_DEFS_SVH

// block geometry and number formats for the MXINT MAC datapath
// all mantissas and exponents are two's complement

// elements per block, all sharing one exponent
`define MX_BLOCK_SIZE 4

// input mantissa width, for activations and weights
`define MX_MAN_W 4

// shared exponent width
// the same width is kept through every stage
`define MX_EXP_W 8

// product blocks summed into one result block
`define MX_IN_DEPTH 2

// mantissa width after the final cast
`define MX_OUT_MAN_W 8

// derived widths live in mxint_pkg:
//   product     = 2 * MX_MAN_W
//   accumulator = product + clog2(MX_IN_DEPTH)

`endif
